/* src/i3c_target_pkg.sv */
/*
  I3C target controller package
  Bus constants, primary FSM states and the structs shared between blocks
*/
package i3c_target_pkg;

  // Bus field widths
  parameter int unsigned AddrWidth = 7;
  parameter int unsigned ByteWidth = 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [ByteWidth-1:0] byte_t;

  // Broadcast header, reserved address 7'h7E with RnW low
  parameter byte_t RsvdByte = 8'hFC;

  // One target identity, dynamic address takes precedence when valid
  typedef struct packed {
    addr_t sta_addr;
    logic  sta_valid;
    addr_t dyn_addr;
    logic  dyn_valid;
  } target_id_t;

  // One-cycle strobes from the bus monitor
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
    logic rst_pattern;
    logic hdr_exit;
  } bus_evt_t;

  // Primary protocol states
  typedef enum logic [4:0] {
    Idle,
    RxFByte,
    CheckFByte,
    TxAckFByte,
    RxSByte,
    RxSByteRepeated,
    CheckSByte,
    TxAckSByte,
    RxPWriteData,
    RxPWriteTbit,
    TxPReadData,
    TxPReadTbit,
    Wait,
    DoIbi,
    DoneIbi,
    DoCcc,
    DoneCcc,
    DoRstAction,
    DoHdrExit
  } state_e;

  // Header decode results
  typedef struct packed {
    logic rsvd;
    logic own;
    logic any;
    logic rnw;
  } hdr_match_t;

endpackage

/* src/i3c_addr_decoder.sv */
/*
  I3C header decoder
  Latches the header byte and matches it against the broadcast address and
  every target identity, also holds the broadcast CCC code
*/
module i3c_addr_decoder #(
  parameter int unsigned NumIds = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  i3c_target_pkg::state_e                  state_i,
  input  logic                                    bus_rx_done_i,
  input  i3c_target_pkg::byte_t                   bus_rx_data_i,
  input  i3c_target_pkg::target_id_t [NumIds-1:0] target_ids_i,
  output i3c_target_pkg::hdr_match_t              match_o,
  output i3c_target_pkg::byte_t                   ccc_o
);
  import i3c_target_pkg::*;

  addr_t             addr_q;
  logic              rnw_q;
  logic              hdr_capture;
  logic              ccc_capture;
  logic [NumIds-1:0] id_hit;

  // Any byte received in a header state may be an address
  assign hdr_capture = bus_rx_done_i &
                       (state_i inside {RxFByte, RxSByte, RxSByteRepeated});
  // After a broadcast header the second byte is the command code
  assign ccc_capture = bus_rx_done_i & (state_i == RxSByte);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end else if (hdr_capture) begin
      addr_q <= bus_rx_data_i[ByteWidth-1:1];
      rnw_q  <= bus_rx_data_i[0];
    end else if (state_i == Idle) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ccc_o <= '0;
    end else if (ccc_capture) begin
      ccc_o <= bus_rx_data_i;
    end
  end

  // Per identity match
  // Dynamic address wins, static is a fallback, none valid never matches
  always_comb begin
    id_hit = '0;
    for (int i = 0; i < NumIds; i++) begin
      if (target_ids_i[i].dyn_valid) begin
        id_hit[i] = (target_ids_i[i].dyn_addr == addr_q);
      end else if (target_ids_i[i].sta_valid) begin
        id_hit[i] = (target_ids_i[i].sta_addr == addr_q);
      end
    end
  end

  assign match_o.rsvd = ({addr_q, rnw_q} == RsvdByte);
  // Identity 0 is the real target
  assign match_o.own  = id_hit[0];
  assign match_o.any  = |id_hit;
  assign match_o.rnw  = rnw_q;

endmodule

/* src/i3c_target_fsm.sv */
/*
  I3C target primary FSM
  Follows SDR traffic after START, requests bytes and bits from the bus layer
  and hands over to the IBI and CCC engines
*/
module i3c_target_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       target_enable_i,
  input  logic                       ibi_enable_i,
  input  logic                       ibi_pending_i,
  input  logic                       ibi_done_i,
  input  logic                       ccc_done_i,
  input  i3c_target_pkg::bus_evt_t   bus_evt_i,
  input  logic                       bus_rx_done_i,
  input  logic                       bus_tx_done_i,
  input  i3c_target_pkg::hdr_match_t match_i,
  input  logic                       tx_more_i,
  output i3c_target_pkg::state_e     state_o,
  output logic                       bus_rx_req_byte_o,
  output logic                       bus_rx_req_bit_o,
  output logic                       bus_tx_req_byte_o,
  output logic                       bus_tx_req_bit_o,
  output logic                       target_idle_o,
  output logic                       ibi_begin_o,
  output logic                       ccc_valid_o,
  output logic                       event_target_nack_o
);
  import i3c_target_pkg::*;

  state_e state_q, state_d;
  logic   bus_start;
  logic   nack_q;

  // Repeated START behaves like START
  assign bus_start = bus_evt_i.start | bus_evt_i.rstart;

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (target_enable_i) begin
          if (bus_evt_i.rst_pattern) state_d = DoRstAction;
          else if (ibi_pending_i && ibi_enable_i) state_d = DoIbi;
          else if (bus_start) state_d = RxFByte;
        end
      end
      RxFByte: begin
        if (bus_rx_done_i) state_d = CheckFByte;
      end
      CheckFByte: begin
        // Broadcast or any identity is acknowledged
        state_d = (match_i.rsvd || match_i.any) ? TxAckFByte : Wait;
      end
      TxAckFByte: begin
        if (bus_tx_done_i) begin
          if (match_i.rsvd) state_d = RxSByte;
          else if (match_i.any) state_d = match_i.rnw ? TxPReadData : RxPWriteData;
          else state_d = Wait;
        end
      end
      RxSByte: begin
        // Sr after 7E means a directed address follows
        if (bus_start) state_d = RxSByteRepeated;
        else if (bus_rx_done_i) state_d = DoCcc;
      end
      RxSByteRepeated: begin
        if (bus_rx_done_i) state_d = CheckSByte;
      end
      CheckSByte: begin
        state_d = match_i.any ? TxAckSByte : Wait;
      end
      TxAckSByte: begin
        // Virtual targets are acknowledged but get no data loop here
        if (bus_tx_done_i) begin
          if (match_i.own) state_d = match_i.rnw ? TxPReadData : RxPWriteData;
          else state_d = Wait;
        end
      end
      RxPWriteData: begin
        if (bus_start) state_d = RxFByte;
        else if (bus_evt_i.stop) state_d = Idle;
        else if (bus_rx_done_i) state_d = RxPWriteTbit;
      end
      RxPWriteTbit: begin
        if (bus_start) state_d = RxFByte;
        else if (bus_evt_i.stop) state_d = Idle;
        else if (bus_rx_done_i) state_d = RxPWriteData;
      end
      TxPReadData: begin
        if (bus_start) state_d = RxFByte;
        else if (bus_evt_i.stop) state_d = Idle;
        else if (bus_tx_done_i) state_d = TxPReadTbit;
      end
      TxPReadTbit: begin
        // End of data parks the target until the host closes the transfer
        if (bus_start) state_d = RxFByte;
        else if (bus_evt_i.stop) state_d = Idle;
        else if (bus_tx_done_i) state_d = tx_more_i ? TxPReadData : Wait;
      end
      Wait: begin
        if (bus_start) state_d = RxFByte;
        else if (bus_evt_i.stop) state_d = Idle;
      end
      DoIbi: begin
        if (ibi_done_i) state_d = DoneIbi;
      end
      DoCcc: begin
        if (ccc_done_i) state_d = DoneCcc;
      end
      DoneIbi, DoneCcc, DoRstAction, DoHdrExit: begin
        state_d = Idle;
      end
      default: begin
        state_d = Idle;
      end
    endcase
    // HDR exit pattern overrides every state
    if (bus_evt_i.hdr_exit) state_d = DoHdrExit;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Only an unmatched header counts as a target NACK
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nack_q <= 1'b0;
    end else begin
      nack_q <= (state_q inside {CheckFByte, CheckSByte}) && (state_d == Wait);
    end
  end

  assign state_o             = state_q;
  assign event_target_nack_o = nack_q;

  // Byte request drops as soon as a START shows up
  assign bus_rx_req_byte_o = ~bus_start &
                             (state_q inside {RxFByte, RxSByte, RxSByteRepeated, RxPWriteData});
  assign bus_rx_req_bit_o  = ~bus_start & (state_q == RxPWriteTbit);
  assign bus_tx_req_byte_o = (state_q == TxPReadData);
  // ACK bits and read T-bits
  assign bus_tx_req_bit_o  = state_q inside {TxAckFByte, TxAckSByte, TxPReadTbit};

  assign target_idle_o = (state_q == Idle);
  assign ibi_begin_o   = (state_q == Idle) & target_enable_i & ~bus_evt_i.rst_pattern &
                         ibi_enable_i & ibi_pending_i;
  assign ccc_valid_o   = (state_q == DoCcc);

endmodule

/* src/i3c_rx_path.sv */
/*
  I3C private write path
  Registers data bytes, checks the T-bit and writes the RX FIFO
*/
module i3c_rx_path (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  i3c_target_pkg::state_e state_i,
  input  logic                   bus_rx_done_i,
  input  i3c_target_pkg::byte_t  bus_rx_data_i,
  input  logic                   rx_fifo_wready_i,
  output logic                   rx_fifo_wvalid_o,
  output i3c_target_pkg::byte_t  rx_fifo_wdata_o,
  output logic                   parity_err_o,
  output logic                   rx_overflow_err_o
);
  import i3c_target_pkg::*;

  byte_t data_q;
  logic  in_data_q;
  logic  data_entry;
  logic  parity_bit;
  logic  parity_err_q;
  logic  byte_ovf_q;
  logic  ovf_seen_q;
  logic  tbit_done;

  // Data byte from the bus layer
  always_ff @(posedge clk_i) begin
    if ((state_i == RxPWriteData) && bus_rx_done_i) data_q <= bus_rx_data_i;
  end

  // First cycle of each data byte
  assign data_entry = (state_i == RxPWriteData) & ~in_data_q;
  assign tbit_done  = (state_i == RxPWriteTbit) & bus_rx_done_i;

  // Odd parity, T-bit makes the total count of ones odd
  assign parity_bit   = ^{data_q, 1'b1};
  assign parity_err_o = tbit_done & (bus_rx_data_i[0] != parity_bit);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_data_q    <= 1'b0;
      parity_err_q <= 1'b0;
      byte_ovf_q   <= 1'b0;
      ovf_seen_q   <= 1'b0;
    end else begin
      in_data_q <= (state_i == RxPWriteData);
      // Parity error sticks for the rest of the transfer
      if (parity_err_o) parity_err_q <= 1'b1;
      else if (state_i == Idle) parity_err_q <= 1'b0;
      // FIFO state sampled once per byte
      if (data_entry) byte_ovf_q <= ~rx_fifo_wready_i;
      if (data_entry && !rx_fifo_wready_i) ovf_seen_q <= 1'b1;
      else if (state_i inside {Idle, RxFByte}) ovf_seen_q <= 1'b0;
    end
  end

  // Overflow reported once per transfer
  assign rx_overflow_err_o = data_entry & ~rx_fifo_wready_i & ~ovf_seen_q;

  // Write on the T-bit unless this or an earlier byte went wrong
  assign rx_fifo_wvalid_o = tbit_done & ~parity_err_o & ~parity_err_q & ~byte_ovf_q;
  assign rx_fifo_wdata_o  = data_q;

endmodule

/* src/i3c_tx_path.sv */
/*
  I3C private read path
  Fetches read bytes from the TX FIFO and drives ACK, data and T-bit values
*/
module i3c_tx_path (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  i3c_target_pkg::state_e state_i,
  input  logic                   bus_tx_done_i,
  input  logic                   tx_fifo_rvalid_i,
  input  i3c_target_pkg::byte_t  tx_fifo_rdata_i,
  input  logic                   tx_last_byte_i,
  output logic                   tx_fifo_rready_o,
  output logic                   tx_more_o,
  output i3c_target_pkg::byte_t  bus_tx_value_o
);
  import i3c_target_pkg::*;

  byte_t byte_q;
  logic  in_read_q;
  logic  last_q;
  logic  end_xfer_q;

  // Pop in the first cycle of TxPReadData
  assign tx_fifo_rready_o = (state_i == TxPReadData) & ~in_read_q &
                            tx_fifo_rvalid_i & ~end_xfer_q;

  // FIFO data is valid together with rready
  always_ff @(posedge clk_i) begin
    if (tx_fifo_rready_o) byte_q <= tx_fifo_rdata_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_read_q  <= 1'b0;
      last_q     <= 1'b0;
      end_xfer_q <= 1'b0;
    end else begin
      in_read_q <= (state_i == TxPReadData);
      // Last flag travels with the popped byte
      if (tx_fifo_rready_o) last_q <= tx_last_byte_i;
      // Transfer ends once the T-bit of the last byte is out
      if ((state_i == TxPReadTbit) && bus_tx_done_i && last_q) end_xfer_q <= 1'b1;
      else if (state_i inside {Idle, RxFByte}) end_xfer_q <= 1'b0;
    end
  end

  assign tx_more_o = tx_fifo_rvalid_i & ~last_q & ~end_xfer_q;

  always_comb begin
    // Released line reads as NACK
    bus_tx_value_o = byte_t'(1);
    case (state_i)
      TxAckFByte, TxAckSByte: bus_tx_value_o = '0;
      TxPReadData: bus_tx_value_o = byte_q;
      // T-bit low ends the read
      TxPReadTbit: bus_tx_value_o = {{(ByteWidth-1){1'b0}}, ~last_q};
      default: ;
    endcase
  end

endmodule

/* src/i3c_target_top.sv */
/*
  I3C target controller top level
  Connects the header decoder, the primary FSM and the private read/write paths
*/
module i3c_target_top #(
  parameter int unsigned NumIds = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    target_enable_i,
  input  logic                                    ibi_enable_i,
  // Bus layer
  input  i3c_target_pkg::bus_evt_t                bus_evt_i,
  input  logic                                    bus_rx_done_i,
  input  logic                                    bus_tx_done_i,
  input  i3c_target_pkg::byte_t                   bus_rx_data_i,
  output logic                                    bus_rx_req_byte_o,
  output logic                                    bus_rx_req_bit_o,
  output logic                                    bus_tx_req_byte_o,
  output logic                                    bus_tx_req_bit_o,
  output i3c_target_pkg::byte_t                   bus_tx_value_o,
  // Real target first, virtual targets after it
  input  i3c_target_pkg::target_id_t [NumIds-1:0] target_ids_i,
  // RX FIFO
  output logic                                    rx_fifo_wvalid_o,
  output i3c_target_pkg::byte_t                   rx_fifo_wdata_o,
  input  logic                                    rx_fifo_wready_i,
  // TX FIFO
  input  logic                                    tx_fifo_rvalid_i,
  input  logic                                    tx_last_byte_i,
  input  i3c_target_pkg::byte_t                   tx_fifo_rdata_i,
  output logic                                    tx_fifo_rready_o,
  // IBI and CCC engines
  input  logic                                    ibi_pending_i,
  input  logic                                    ibi_done_i,
  input  logic                                    ccc_done_i,
  output logic                                    ibi_begin_o,
  output logic                                    ccc_valid_o,
  output i3c_target_pkg::byte_t                   ccc_o,
  // Status and events
  output logic                                    target_idle_o,
  output logic                                    event_target_nack_o,
  output logic                                    parity_err_o,
  output logic                                    rx_overflow_err_o
);
  import i3c_target_pkg::*;

  state_e     state;
  hdr_match_t match;
  logic       tx_more;

  // Header and CCC code capture
  i3c_addr_decoder #(
    .NumIds(NumIds)
  ) i3c_addr_decoder_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .state_i      (state),
    .bus_rx_done_i(bus_rx_done_i),
    .bus_rx_data_i(bus_rx_data_i),
    .target_ids_i (target_ids_i),
    .match_o      (match),
    .ccc_o        (ccc_o)
  );

  i3c_target_fsm i3c_target_fsm_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .target_enable_i    (target_enable_i),
    .ibi_enable_i       (ibi_enable_i),
    .ibi_pending_i      (ibi_pending_i),
    .ibi_done_i         (ibi_done_i),
    .ccc_done_i         (ccc_done_i),
    .bus_evt_i          (bus_evt_i),
    .bus_rx_done_i      (bus_rx_done_i),
    .bus_tx_done_i      (bus_tx_done_i),
    .match_i            (match),
    .tx_more_i          (tx_more),
    .state_o            (state),
    .bus_rx_req_byte_o  (bus_rx_req_byte_o),
    .bus_rx_req_bit_o   (bus_rx_req_bit_o),
    .bus_tx_req_byte_o  (bus_tx_req_byte_o),
    .bus_tx_req_bit_o   (bus_tx_req_bit_o),
    .target_idle_o      (target_idle_o),
    .ibi_begin_o        (ibi_begin_o),
    .ccc_valid_o        (ccc_valid_o),
    .event_target_nack_o(event_target_nack_o)
  );

  // Private write
  i3c_rx_path i3c_rx_path_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .state_i          (state),
    .bus_rx_done_i    (bus_rx_done_i),
    .bus_rx_data_i    (bus_rx_data_i),
    .rx_fifo_wready_i (rx_fifo_wready_i),
    .rx_fifo_wvalid_o (rx_fifo_wvalid_o),
    .rx_fifo_wdata_o  (rx_fifo_wdata_o),
    .parity_err_o     (parity_err_o),
    .rx_overflow_err_o(rx_overflow_err_o)
  );

  // Private read and ACK values
  i3c_tx_path i3c_tx_path_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .state_i         (state),
    .bus_tx_done_i   (bus_tx_done_i),
    .tx_fifo_rvalid_i(tx_fifo_rvalid_i),
    .tx_fifo_rdata_i (tx_fifo_rdata_i),
    .tx_last_byte_i  (tx_last_byte_i),
    .tx_fifo_rready_o(tx_fifo_rready_o),
    .tx_more_o       (tx_more),
    .bus_tx_value_o  (bus_tx_value_o)
  );

endmodule

/* sim/i3c_target_tb.sv */
/*
  I3C target controller testbench
  Behavioral bus layer, FIFOs and engines driven from a table of transfers
*/
module i3c_target_tb;
  import i3c_target_pkg::*;

  localparam int NumRows       = 8;
  localparam int MaxRowCycles  = 120;
  localparam int TimeoutCycles = NumRows * MaxRowCycles + 100;

  // One transfer with its expected results
  typedef struct packed {
    logic        is_ibi;
    byte_t       hdr;
    byte_t       cmd;
    logic [2:0]  n_data;
    logic [31:0] data;
    logic [3:0]  bad_tbit;
    logic        rx_ready;
    logic        exp_ack;
    logic [2:0]  exp_nwr;
    logic [1:0]  exp_perr;
    logic [1:0]  exp_ovf;
    logic [1:0]  exp_nack;
  } row_t;

  logic clk_i, rst_ni, target_enable_i, ibi_enable_i;
  bus_evt_t bus_evt_i;
  logic bus_rx_done_i, bus_tx_done_i;
  byte_t bus_rx_data_i, bus_tx_value_o;
  logic bus_rx_req_byte_o, bus_rx_req_bit_o, bus_tx_req_byte_o, bus_tx_req_bit_o;
  target_id_t id0, id1;
  target_id_t [1:0] target_ids_i;
  logic rx_fifo_wvalid_o, rx_fifo_wready_i, tx_fifo_rvalid_i, tx_last_byte_i, tx_fifo_rready_o;
  byte_t rx_fifo_wdata_o, tx_fifo_rdata_i, ccc_o;
  logic ibi_pending_i, ibi_done_i, ccc_done_i, ibi_begin_o, ccc_valid_o;
  logic target_idle_o, event_target_nack_o, parity_err_o, rx_overflow_err_o;

  row_t   rows [NumRows];
  byte_t  wr_q [$];
  integer seed;
  int     perr_cnt, ovf_cnt, nack_cnt;
  int     checks, errors, row_errors, cycle_cnt;

  i3c_target_top #(.NumIds(2)) i3c_target_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Run limit, sized from the table length
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: the DUT did not answer within %0d cycles", TimeoutCycles);
    $display("Testbench failed");
    $finish;
  end

  // Output pulses are sampled mid cycle
  always @(negedge clk_i) begin
    if (rx_fifo_wvalid_o) wr_q.push_back(rx_fifo_wdata_o);
    if (parity_err_o) perr_cnt++;
    if (rx_overflow_err_o) ovf_cnt++;
    if (event_target_nack_o) nack_cnt++;
  end

  function automatic row_t mk_row(input logic is_ibi, input byte_t hdr, input byte_t cmd,
                                  input int n, input logic [31:0] data, input logic [3:0] bad,
                                  input logic ready, input logic ack, input int nwr,
                                  input int perr, input int ovf, input int nack);
    row_t r;
    r = '0;
    r.is_ibi = is_ibi;
    r.hdr = hdr;
    r.cmd = cmd;
    r.n_data = n;
    r.data = data;
    r.bad_tbit = bad;
    r.rx_ready = ready;
    r.exp_ack = ack;
    r.exp_nwr = nwr;
    r.exp_perr = perr;
    r.exp_ovf = ovf;
    r.exp_nack = nack;
    return r;
  endfunction

  // T-bit that makes the count of ones odd
  function automatic logic odd_tbit(input byte_t b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) ones += b[i];
    return (ones % 2 == 0);
  endfunction

  task automatic check_eq(input string what, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      $display("Error: time %0t, %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
      row_errors++;
    end
  endtask

  // Host and bus layer answer after 1 to 4 cycles
  task automatic pause_random();
    int d;
    d = 1 + ($unsigned($random(seed)) % 4);
    repeat (d) @(negedge clk_i);
  endtask

  task automatic pulse_rx_done(input byte_t data);
    @(posedge clk_i);
    bus_rx_done_i <= 1'b1;
    bus_rx_data_i <= data;
    @(posedge clk_i);
    bus_rx_done_i <= 1'b0;
  endtask

  task automatic pulse_tx_done();
    @(posedge clk_i);
    bus_tx_done_i <= 1'b1;
    @(posedge clk_i);
    bus_tx_done_i <= 1'b0;
  endtask

  task automatic send_bus_event(input logic start, input logic stop);
    bus_evt_t ev;
    ev = '0;
    ev.start = start;
    ev.stop = stop;
    @(posedge clk_i);
    bus_evt_i <= ev;
    @(posedge clk_i);
    bus_evt_i <= '0;
  endtask

  task automatic run_bus_row(input row_t r);
    logic        acked;
    logic [31:0] data;
    logic [3:0]  bad;
    int          n;
    data = r.data;
    bad = r.bad_tbit;
    n = r.n_data;
    // FIFO levels for this transfer, TX FIFO holds the read bytes
    @(posedge clk_i);
    rx_fifo_wready_i <= r.rx_ready;
    tx_fifo_rvalid_i <= r.hdr[0] && (n != 0);
    tx_fifo_rdata_i <= data[7:0];
    tx_last_byte_i <= (n == 1);
    send_bus_event(1'b1, 1'b0);
    @(negedge clk_i);
    while (!bus_rx_req_byte_o) @(negedge clk_i);
    pause_random();
    pulse_rx_done(r.hdr);
    // Either an ACK bit request or the NACK event follows the header
    @(negedge clk_i);
    while (!bus_tx_req_bit_o && !event_target_nack_o) @(negedge clk_i);
    acked = bus_tx_req_bit_o && !bus_tx_value_o[0];
    check_eq("header ACK", acked, r.exp_ack);
    if (bus_tx_req_bit_o) begin
      pause_random();
      pulse_tx_done();
    end
    if (acked && r.hdr == RsvdByte) begin
      @(negedge clk_i);
      while (!bus_rx_req_byte_o) @(negedge clk_i);
      pause_random();
      pulse_rx_done(r.cmd);
      @(negedge clk_i);
      while (!ccc_valid_o) @(negedge clk_i);
      check_eq("CCC code", ccc_o, r.cmd);
      pause_random();
      @(posedge clk_i);
      ccc_done_i <= 1'b1;
      @(posedge clk_i);
      ccc_done_i <= 1'b0;
    end else if (acked && r.hdr[0]) begin
      for (int k = 0; k < n; k++) begin
        @(negedge clk_i);
        while (!bus_tx_req_byte_o) @(negedge clk_i);
        check_eq("TX FIFO pop", tx_fifo_rready_o, 1);
        // Next FIFO head after the pop
        @(posedge clk_i);
        tx_fifo_rvalid_i <= (k + 1 < n);
        if (k + 1 < n) tx_fifo_rdata_i <= data[8*(k+1) +: 8];
        tx_last_byte_i <= (k + 2 == n);
        pause_random();
        check_eq("read byte", bus_tx_value_o, data[8*k +: 8]);
        pulse_tx_done();
        @(negedge clk_i);
        while (!bus_tx_req_bit_o) @(negedge clk_i);
        // Only the last byte ends the read
        check_eq("read T-bit", bus_tx_value_o[0], (k != n - 1));
        pause_random();
        pulse_tx_done();
      end
    end else if (acked) begin
      for (int k = 0; k < n; k++) begin
        @(negedge clk_i);
        while (!bus_rx_req_byte_o) @(negedge clk_i);
        pause_random();
        pulse_rx_done(data[8*k +: 8]);
        @(negedge clk_i);
        while (!bus_rx_req_bit_o) @(negedge clk_i);
        pause_random();
        pulse_rx_done({7'd0, odd_tbit(data[8*k +: 8]) ^ bad[k]});
      end
      // Host stops instead of sending another byte
      @(negedge clk_i);
      while (!bus_rx_req_byte_o) @(negedge clk_i);
    end
    send_bus_event(1'b0, 1'b1);
    @(negedge clk_i);
    while (!target_idle_o) @(negedge clk_i);
    check_eq("FIFO writes", wr_q.size(), r.exp_nwr);
    for (int k = 0; k < wr_q.size() && k < 4; k++) check_eq("FIFO data", wr_q[k], data[8*k +: 8]);
    check_eq("parity errors", perr_cnt, r.exp_perr);
    check_eq("overflow errors", ovf_cnt, r.exp_ovf);
    check_eq("target NACKs", nack_cnt, r.exp_nack);
  endtask

  task automatic run_ibi_row();
    @(posedge clk_i);
    ibi_pending_i <= 1'b1;
    @(negedge clk_i);
    check_eq("IBI begin", ibi_begin_o, 1);
    @(negedge clk_i);
    check_eq("busy in IBI", target_idle_o, 0);
    pause_random();
    @(posedge clk_i);
    ibi_done_i <= 1'b1;
    ibi_pending_i <= 1'b0;
    @(posedge clk_i);
    ibi_done_i <= 1'b0;
    // One cycle in DoneIbi, then Idle
    repeat (2) @(negedge clk_i);
    check_eq("idle after IBI", target_idle_o, 1);
    check_eq("IBI begin after done", ibi_begin_o, 0);
  endtask

  initial begin
    seed = 18032;
    checks = 0;
    errors = 0;
    rst_ni = 1'b0;
    target_enable_i = 1'b1;
    ibi_enable_i = 1'b1;
    bus_evt_i = '0;
    bus_rx_done_i = 1'b0;
    bus_tx_done_i = 1'b0;
    bus_rx_data_i = '0;
    rx_fifo_wready_i = 1'b1;
    tx_fifo_rvalid_i = 1'b0;
    tx_last_byte_i = 1'b0;
    tx_fifo_rdata_i = '0;
    ibi_pending_i = 1'b0;
    ibi_done_i = 1'b0;
    ccc_done_i = 1'b0;
    // Real target at dynamic 0x30 over static 0x50, virtual target at static 0x22
    id0 = {7'h50, 1'b1, 7'h30, 1'b1};
    id1 = {7'h22, 1'b1, 7'h00, 1'b0};
    target_ids_i = {id1, id0};
    //               ibi hdr    cmd    n  data          bad   rdy ack wr pe ov nk
    rows[0] = mk_row(0, 8'h60, 8'h00, 3, 32'h00013CA5, 4'h0, 1, 1, 3, 0, 0, 0);
    rows[1] = mk_row(0, 8'hA0, 8'h00, 0, 32'h00000000, 4'h0, 1, 0, 0, 0, 0, 1);
    rows[2] = mk_row(0, 8'h60, 8'h00, 4, 32'h44332211, 4'h2, 1, 1, 1, 1, 0, 0);
    rows[3] = mk_row(0, 8'h45, 8'h00, 3, 32'h007EC35A, 4'h0, 1, 1, 0, 0, 0, 0);
    rows[4] = mk_row(0, 8'h60, 8'h00, 2, 32'h0000F00F, 4'h0, 0, 1, 0, 0, 1, 0);
    rows[5] = mk_row(0, 8'hFC, 8'h07, 0, 32'h00000000, 4'h0, 1, 1, 0, 0, 0, 0);
    rows[6] = mk_row(1, 8'h00, 8'h00, 0, 32'h00000000, 4'h0, 1, 0, 0, 0, 0, 0);
    rows[7] = mk_row(0, 8'h61, 8'h00, 1, 32'h0000009C, 4'h0, 1, 1, 0, 0, 0, 0);
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_eq("idle after reset", target_idle_o, 1);
    for (int i = 0; i < NumRows; i++) begin
      @(posedge clk_i);
      row_errors = 0;
      perr_cnt = 0;
      ovf_cnt = 0;
      nack_cnt = 0;
      wr_q.delete();
      if (rows[i].is_ibi) run_ibi_row();
      else run_bus_row(rows[i]);
      $display("Row %0d header %h: %s", i, rows[i].hdr, (row_errors == 0) ? "ok" : "mismatch");
    end
    $display("Rows: %0d, checks: %0d, errors: %0d", NumRows, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
src/i3c_target_pkg.sv
src/i3c_addr_decoder.sv
src/i3c_target_fsm.sv
src/i3c_rx_path.sv
src/i3c_tx_path.sv
src/i3c_target_top.sv
sim/i3c_target_tb.sv
